//--- rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// gpio block sits in a 16 byte window at this base
`define RV_GPIO_BASE 32'h8000_0000

// register offsets inside the gpio window
`define RV_GPIO_OUT_OFS 4'h0
`define RV_GPIO_OE_OFS  4'h4
`define RV_GPIO_IN_OFS  4'h8

// byte lanes, always full word on this core
`define RV_SEL_WORD 4'hF

// instruction length in bytes
`define RV_INST_BYTES 32'd4

`endif

//--- rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [31:0] word_t;     // data, address or instruction
  typedef logic [4:0]  reg_addr_t; // x0..x31

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JAL,
    BR_JALR
  } br_type_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    br_type_e  br_type;
    wb_sel_e   wb_sel;
    logic      use_imm;   // operand b from imm
    logic      use_pc;    // operand a from pc, auipc
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } rv_ctrl_t;

  typedef struct packed {
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
    logic       read;
    logic       write;
  } bus_req_t;

  typedef enum logic [1:0] {
    SEQ_FETCH,
    SEQ_EXEC,
    SEQ_MEM
  } seq_state_e;

endpackage

//--- rv_bus_seq.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_bus_seq (
  input  logic                  i_clock,
  input  logic                  i_rst_n,
  input  logic                  i_busy,
  input  rv_core_pkg::word_t    i_dat,
  input  logic                  i_taken,
  input  rv_core_pkg::word_t    i_target,
  input  rv_core_pkg::bus_req_t i_data_req,
  input  logic                  i_gpio_hit,
  output rv_core_pkg::bus_req_t o_req,
  output rv_core_pkg::word_t    o_inst,
  output rv_core_pkg::word_t    o_pc,
  output logic                  o_exec,
  output logic                  o_mem_done
);

  rv_core_pkg::seq_state_e state_q;
  rv_core_pkg::seq_state_e state_d;
  rv_core_pkg::word_t      pc_q;
  rv_core_pkg::word_t      pc_d;
  rv_core_pkg::word_t      inst_q;
  logic                    bus_access; // data access leaving the core
  logic                    retire;     // last cycle of the instruction

  assign bus_access = (i_data_req.read || i_data_req.write) && !i_gpio_hit;

  always_comb begin
    state_d = state_q;
    retire  = 1'b0;
    unique case (state_q)
      rv_core_pkg::SEQ_FETCH: begin
        if (!i_busy) begin
          state_d = rv_core_pkg::SEQ_EXEC;
        end
      end
      rv_core_pkg::SEQ_EXEC: begin
        if (bus_access) begin
          state_d = rv_core_pkg::SEQ_MEM; // lw/sw out to the bus
        end else begin
          state_d = rv_core_pkg::SEQ_FETCH;
          retire  = 1'b1;
        end
      end
      rv_core_pkg::SEQ_MEM: begin
        if (!i_busy) begin
          state_d = rv_core_pkg::SEQ_FETCH;
          retire  = 1'b1;
        end
      end
      default: state_d = rv_core_pkg::SEQ_FETCH;
    endcase
  end

  assign pc_d = i_taken ? i_target : pc_q + `RV_INST_BYTES;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state_q <= rv_core_pkg::SEQ_FETCH;
      pc_q    <= `RV_RESET_PC;
    end else begin
      state_q <= state_d;
      if (retire) begin
        pc_q <= pc_d;
      end
    end
  end

  // fetched word, taken at the completing edge
  always_ff @(posedge i_clock) begin
    if (state_q == rv_core_pkg::SEQ_FETCH && !i_busy) begin
      inst_q <= i_dat;
    end
  end

  // request mux, held steady for the whole phase
  always_comb begin
    o_req = '{adr: pc_q, dat: '0, sel: `RV_SEL_WORD, read: 1'b0, write: 1'b0};
    if (state_q == rv_core_pkg::SEQ_FETCH) begin
      o_req.read = 1'b1;
    end else if (state_q == rv_core_pkg::SEQ_MEM) begin
      o_req = i_data_req;
    end
  end

  assign o_inst     = inst_q;
  assign o_pc       = pc_q;
  assign o_exec     = (state_q == rv_core_pkg::SEQ_EXEC);
  assign o_mem_done = (state_q == rv_core_pkg::SEQ_MEM) && !i_busy;

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_core_pkg::word_t    i_inst,
  output rv_core_pkg::rv_ctrl_t o_ctrl
);

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 to alu op, alt picks sub/sra
  function automatic rv_core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                            input logic alt);
    rv_core_pkg::alu_op_e op;
    unique case (f3)
      3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  op = rv_core_pkg::ALU_SLL;
      3'b010:  op = rv_core_pkg::ALU_SLT;
      3'b011:  op = rv_core_pkg::ALU_SLTU;
      3'b100:  op = rv_core_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  op = rv_core_pkg::ALU_OR;
      default: op = rv_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl           = '0;         // unknown opcode ends up a no-op
    o_ctrl.rs1       = i_inst[19:15];
    o_ctrl.rs2       = i_inst[24:20];
    o_ctrl.rd        = i_inst[11:7];
    o_ctrl.alu_op    = rv_core_pkg::ALU_ADD;
    o_ctrl.br_type   = rv_core_pkg::BR_NONE;
    o_ctrl.wb_sel    = rv_core_pkg::WB_ALU;
    unique case (opcode)
      OP_REG: begin
        // only 0000000, or 0100000 for sub and sra
        if (funct7 == 7'b0 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          o_ctrl.alu_op    = alu_from_funct3(funct3, i_inst[30]);
          o_ctrl.reg_write = 1'b1;
        end
      end
      OP_IMM: begin
        o_ctrl.imm       = imm_i;
        o_ctrl.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_ctrl.use_imm   = 1'b1;
        o_ctrl.reg_write = 1'b1;
      end
      OP_LUI: begin
        o_ctrl.imm       = imm_u;
        o_ctrl.alu_op    = rv_core_pkg::ALU_PASS_B;
        o_ctrl.use_imm   = 1'b1;
        o_ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        o_ctrl.imm       = imm_u;
        o_ctrl.use_imm   = 1'b1;
        o_ctrl.use_pc    = 1'b1;
        o_ctrl.reg_write = 1'b1;
      end
      OP_LOAD: begin
        if (funct3 == 3'b010) begin // lw only
          o_ctrl.imm       = imm_i;
          o_ctrl.use_imm   = 1'b1;
          o_ctrl.wb_sel    = rv_core_pkg::WB_MEM;
          o_ctrl.reg_write = 1'b1;
          o_ctrl.mem_read  = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 == 3'b010) begin // sw only
          o_ctrl.imm       = imm_s;
          o_ctrl.use_imm   = 1'b1;
          o_ctrl.mem_write = 1'b1;
        end
      end
      OP_BRANCH: begin
        o_ctrl.imm = imm_b;
        unique case (funct3)
          3'b000:  o_ctrl.br_type = rv_core_pkg::BR_EQ;
          3'b001:  o_ctrl.br_type = rv_core_pkg::BR_NE;
          3'b100:  o_ctrl.br_type = rv_core_pkg::BR_LT;
          3'b101:  o_ctrl.br_type = rv_core_pkg::BR_GE;
          default: o_ctrl.br_type = rv_core_pkg::BR_NONE; // bltu/bgeu dropped
        endcase
      end
      OP_JAL: begin
        o_ctrl.imm       = imm_j;
        o_ctrl.br_type   = rv_core_pkg::BR_JAL;
        o_ctrl.wb_sel    = rv_core_pkg::WB_PC4;
        o_ctrl.reg_write = 1'b1;
      end
      OP_JALR: begin
        o_ctrl.imm       = imm_i;
        o_ctrl.br_type   = rv_core_pkg::BR_JALR;
        o_ctrl.wb_sel    = rv_core_pkg::WB_PC4;
        o_ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   i_clock,
  input  logic                   i_rst_n,
  input  logic                   i_we,
  input  rv_core_pkg::reg_addr_t i_rd,
  input  rv_core_pkg::word_t     i_wdata,
  input  rv_core_pkg::reg_addr_t i_rs1,
  input  rv_core_pkg::reg_addr_t i_rs2,
  output rv_core_pkg::word_t     o_rdata1,
  output rv_core_pkg::word_t     o_rdata2
);

  rv_core_pkg::word_t regs [32];

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin // x0 never written
      regs[i_rd] <= i_wdata;
    end
  end

  // async read ports
  assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::rv_ctrl_t i_ctrl,
  input  rv_core_pkg::word_t    i_rs1_data,
  input  rv_core_pkg::word_t    i_rs2_data,
  input  rv_core_pkg::word_t    i_pc,
  input  rv_core_pkg::word_t    i_load_data,
  output rv_core_pkg::word_t    o_result,
  output rv_core_pkg::word_t    o_wb_data,
  output rv_core_pkg::word_t    o_target,
  output logic                  o_taken
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t jalr_sum;
  logic [4:0]         shamt;
  logic               eq;
  logic               lt; // signed compare of rs1 and rs2

  assign op_a  = i_ctrl.use_pc ? i_pc : i_rs1_data;
  assign op_b  = i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    unique case (i_ctrl.alu_op)
      rv_core_pkg::ALU_ADD:    o_result = op_a + op_b;
      rv_core_pkg::ALU_SUB:    o_result = op_a - op_b;
      rv_core_pkg::ALU_AND:    o_result = op_a & op_b;
      rv_core_pkg::ALU_OR:     o_result = op_a | op_b;
      rv_core_pkg::ALU_XOR:    o_result = op_a ^ op_b;
      rv_core_pkg::ALU_SLT:    o_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::ALU_SLTU:   o_result = {31'b0, op_a < op_b};
      rv_core_pkg::ALU_SLL:    o_result = op_a << shamt;
      rv_core_pkg::ALU_SRL:    o_result = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    o_result = $unsigned($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_PASS_B: o_result = op_b;
      default:                 o_result = '0;
    endcase
  end

  assign eq = (i_rs1_data == i_rs2_data);
  assign lt = $signed(i_rs1_data) < $signed(i_rs2_data);

  always_comb begin
    unique case (i_ctrl.br_type)
      rv_core_pkg::BR_EQ:   o_taken = eq;
      rv_core_pkg::BR_NE:   o_taken = !eq;
      rv_core_pkg::BR_LT:   o_taken = lt;
      rv_core_pkg::BR_GE:   o_taken = !lt;
      rv_core_pkg::BR_JAL,
      rv_core_pkg::BR_JALR: o_taken = 1'b1;
      default:              o_taken = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_ctrl.imm;
  assign o_target = (i_ctrl.br_type == rv_core_pkg::BR_JALR) ? {jalr_sum[31:1], 1'b0}
                                                              : i_pc + i_ctrl.imm;

  always_comb begin
    unique case (i_ctrl.wb_sel)
      rv_core_pkg::WB_MEM: o_wb_data = i_load_data;
      rv_core_pkg::WB_PC4: o_wb_data = i_pc + 32'd4; // link value
      default:             o_wb_data = o_result;
    endcase
  end

endmodule

//--- rv_gpio.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_gpio (
  input  logic                  i_clock,
  input  logic                  i_rst_n,
  input  rv_core_pkg::rv_ctrl_t i_ctrl,
  input  logic                  i_exec,
  input  rv_core_pkg::word_t    i_addr,
  input  rv_core_pkg::word_t    i_wdata,
  input  rv_core_pkg::word_t    i_bus_rdata,
  input  rv_core_pkg::word_t    i_gpio_in,
  output logic                  o_hit,
  output rv_core_pkg::word_t    o_load_data,
  output rv_core_pkg::bus_req_t o_data_req,
  output rv_core_pkg::word_t    o_gpio_out,
  output rv_core_pkg::word_t    o_gpio_oe
);

  localparam rv_core_pkg::word_t GPIO_BASE = `RV_GPIO_BASE;

  rv_core_pkg::word_t out_q, oe_q;
  rv_core_pkg::word_t in_meta_q, in_sync_q; // two flop input sync
  logic               access;

  assign access = i_ctrl.mem_read || i_ctrl.mem_write;
  assign o_hit  = access && (i_addr[31:4] == GPIO_BASE[31:4]);

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      out_q     <= '0;
      oe_q      <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= i_gpio_in;
      in_sync_q <= in_meta_q;
      if (i_exec && o_hit && i_ctrl.mem_write) begin
        unique case (i_addr[3:0])
          `RV_GPIO_OUT_OFS: out_q <= i_wdata;
          `RV_GPIO_OE_OFS:  oe_q  <= i_wdata;
          default: ;                            // input reg is read only
        endcase
      end
    end
  end

  always_comb begin
    o_load_data = i_bus_rdata; // forwarded from the bus
    if (o_hit) begin
      unique case (i_addr[3:0])
        `RV_GPIO_OUT_OFS: o_load_data = out_q;
        `RV_GPIO_OE_OFS:  o_load_data = oe_q;
        `RV_GPIO_IN_OFS:  o_load_data = in_sync_q;
        default:          o_load_data = '0;
      endcase
    end
  end

  // everything outside the window goes to the bus
  assign o_data_req = '{adr: i_addr, dat: i_wdata, sel: `RV_SEL_WORD,
                        read: i_ctrl.mem_read && !o_hit, write: i_ctrl.mem_write && !o_hit};

  assign o_gpio_out = out_q;
  assign o_gpio_oe  = oe_q;

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic               i_clock,
  input  logic               i_rst_n,
  input  rv_core_pkg::word_t i_dat,
  input  logic               i_busy,
  input  rv_core_pkg::word_t i_gpio_in,
  output rv_core_pkg::word_t o_adr,
  output rv_core_pkg::word_t o_dat,
  output logic [3:0]         o_sel,
  output logic               o_read,
  output logic               o_write,
  output rv_core_pkg::word_t o_gpio_out,
  output rv_core_pkg::word_t o_gpio_oe
);

  rv_core_pkg::bus_req_t req, data_req;
  rv_core_pkg::rv_ctrl_t ctrl;
  rv_core_pkg::word_t    inst, pc;
  rv_core_pkg::word_t    rs1_data, rs2_data;
  rv_core_pkg::word_t    result, wb_data, target, load_data;
  logic                  taken, exec, mem_done, gpio_hit;
  logic                  rf_we;

  rv_bus_seq u_seq (
    .i_clock(i_clock), .i_rst_n(i_rst_n), .i_busy(i_busy), .i_dat(i_dat),
    .i_taken(taken), .i_target(target), .i_data_req(data_req), .i_gpio_hit(gpio_hit),
    .o_req(req), .o_inst(inst), .o_pc(pc), .o_exec(exec), .o_mem_done(mem_done));

  rv_decode u_dec (.i_inst(inst), .o_ctrl(ctrl));

  rv_regfile u_rf (
    .i_clock(i_clock), .i_rst_n(i_rst_n), .i_we(rf_we), .i_rd(ctrl.rd), .i_wdata(wb_data),
    .i_rs1(ctrl.rs1), .i_rs2(ctrl.rs2), .o_rdata1(rs1_data), .o_rdata2(rs2_data));

  rv_execute u_ex (
    .i_ctrl(ctrl), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_pc(pc),
    .i_load_data(load_data), .o_result(result), .o_wb_data(wb_data), .o_target(target),
    .o_taken(taken));

  rv_gpio u_gpio (
    .i_clock(i_clock), .i_rst_n(i_rst_n), .i_ctrl(ctrl), .i_exec(exec), .i_addr(result),
    .i_wdata(rs2_data), .i_bus_rdata(i_dat), .i_gpio_in(i_gpio_in), .o_hit(gpio_hit),
    .o_load_data(load_data), .o_data_req(data_req), .o_gpio_out(o_gpio_out),
    .o_gpio_oe(o_gpio_oe));

  // loads write back when their data lands
  always_comb begin
    rf_we = 1'b0;
    if (ctrl.reg_write) begin
      if (ctrl.mem_read) begin
        rf_we = mem_done || (exec && gpio_hit);
      end else begin
        rf_we = exec;
      end
    end
  end

  assign o_adr   = req.adr;
  assign o_dat   = req.dat;
  assign o_sel   = req.sel;
  assign o_read  = req.read;
  assign o_write = req.write;

endmodule

//--- rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
  input logic               i_clock,
  input logic               i_rst_n,
  input logic               i_busy,
  input rv_core_pkg::word_t o_adr,
  input rv_core_pkg::word_t o_dat,
  input logic               o_read,
  input logic               o_write
);

  a_one_dir: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    !(o_read && o_write)) else $error("read and write high together");

  // request held while the slave stalls
  a_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (o_read || o_write) && i_busy |=>
      $stable(o_adr) && $stable(o_dat) && $stable(o_read) && $stable(o_write))
    else $error("request changed under busy");

  a_align: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (o_read || o_write) |-> o_adr[1:0] == 2'b00) else $error("unaligned address");

  a_rst_wr: assert property (@(posedge i_clock)
    $rose(i_rst_n) |-> !o_write) else $error("write right after reset");

endmodule

bind rv_core rv_core_chk u_chk (.i_clock(i_clock), .i_rst_n(i_rst_n), .i_busy(i_busy),
  .o_adr(o_adr), .o_dat(o_dat), .o_read(o_read), .o_write(o_write));

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core;

  localparam rv_core_pkg::word_t GPIO_BASE   = `RV_GPIO_BASE;
  localparam rv_core_pkg::word_t GPIO_IN_VAL = 32'hC0FF_EE15;
  localparam rv_core_pkg::word_t DONE_ADR    = 32'h0000_07FC;

  logic i_clock, i_rst_n, i_busy, o_read, o_write;
  logic [3:0] o_sel;
  rv_core_pkg::word_t i_dat, i_gpio_in, o_adr, o_dat, o_gpio_out, o_gpio_oe;

  rv_core_pkg::word_t   mem [512];     // byte address bits 10:2
  rv_core_pkg::word_t   ref_mem [512];
  rv_core_pkg::bus_req_t exp_bus [$];
  rv_core_pkg::word_t   exp_out [$], exp_oe [$];
  rv_core_pkg::bus_req_t cur, first_exp;
  rv_core_pkg::word_t   prev_out, prev_oe;
  int seed, delay, busy_left, errors, checks, cycles, cycle_limit, n_inst, p, so;
  logic first_seen, done;

  rv_core uut (.i_clock(i_clock), .i_rst_n(i_rst_n), .i_dat(i_dat), .i_busy(i_busy),
    .i_gpio_in(i_gpio_in), .o_adr(o_adr), .o_dat(o_dat), .o_sel(o_sel), .o_read(o_read),
    .o_write(o_write), .o_gpio_out(o_gpio_out), .o_gpio_oe(o_gpio_oe));

  // memory read port follows the held address
  assign i_dat = mem[o_adr[10:2]];

  function automatic rv_core_pkg::word_t r_t(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction
  function automatic rv_core_pkg::word_t i_t(int imm, int rs1, int f3, int rd,
                                             logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction
  function automatic rv_core_pkg::word_t s_t(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction
  function automatic rv_core_pkg::word_t b_t(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction
  function automatic rv_core_pkg::word_t u_t(int imm, int rd, logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction
  function automatic rv_core_pkg::word_t j_t(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic emit(input rv_core_pkg::word_t w);
    mem[p] = w;
    p++;
  endtask

  task automatic st(input int rs); // result slot in the store area
    emit(s_t(so, rs, 0));
    so += 4;
  endtask

  task automatic load_program();
    int pair_a [3];
    int pair_b [3];
    int brf [4];
    pair_a = '{1, 2, 1};
    pair_b = '{2, 1, 1};
    brf    = '{0, 1, 4, 5};
    p = 0;
    so = 32'h400;
    emit(i_t(-5, 0, 0, 1, 7'h13));
    emit(i_t(3, 0, 0, 2, 7'h13));
    for (int k = 0; k < 8; k++) begin
      emit(r_t(0, 2, 1, k, 3));
      st(3);
    end
    emit(r_t(32, 2, 1, 0, 3)); // sub
    st(3);
    emit(r_t(32, 2, 1, 5, 3)); // sra of a negative value
    st(3);
    emit(r_t(0, 1, 2, 2, 3));  // slt with swapped operands
    st(3);
    emit(r_t(0, 1, 2, 3, 3));
    st(3);
    foreach (brf[k]) begin
      emit(i_t(-100, 1, brf[k] == 1 ? 0 : brf[k] + 2, 4, 7'h13));
      st(4);
    end
    emit(i_t(7, 1, 1, 4, 7'h13));
    st(4);
    emit(i_t(9, 1, 5, 4, 7'h13));
    st(4);
    emit(i_t(32'h409, 1, 5, 4, 7'h13));
    st(4);
    emit(u_t(32'h12345, 5, 7'h37));
    st(5);
    emit(u_t(1, 6, 7'h17));
    st(6);
    emit(i_t(5, 0, 0, 7, 7'h13));    // counted loop summing 5..1
    emit(i_t(0, 0, 0, 8, 7'h13));
    emit(r_t(0, 7, 8, 0, 8));
    emit(i_t(-1, 7, 0, 7, 7'h13));
    emit(b_t(-8, 0, 7, 1));
    st(8);
    foreach (brf[k]) begin
      for (int q = 0; q < 3; q++) begin
        emit(i_t(11, 0, 0, 9, 7'h13));
        emit(b_t(8, pair_b[q], pair_a[q], brf[k]));
        emit(i_t(22, 0, 0, 9, 7'h13));
        st(9);
      end
    end
    emit(j_t(8, 10));
    emit(i_t(99, 0, 0, 11, 7'h13)); // skipped by jal
    st(10);
    st(11);
    emit(u_t(0, 12, 7'h17));
    emit(i_t(12, 12, 0, 13, 7'h67));
    emit(i_t(77, 0, 0, 11, 7'h13)); // skipped by jalr
    st(13);
    st(11);
    emit(i_t(32'h700, 0, 2, 14, 7'h03));
    emit(i_t(1000, 14, 0, 14, 7'h13));
    st(14);
    emit(i_t(32'h704, 0, 2, 15, 7'h03));
    emit(r_t(32, 14, 15, 0, 15));
    st(15);
    emit(u_t(32'h80000, 16, 7'h37));
    emit(i_t(32'h5A5, 0, 0, 17, 7'h13));
    emit(s_t(0, 17, 16));
    emit(i_t(-1, 0, 0, 17, 7'h13));
    emit(s_t(4, 17, 16));
    emit(i_t(8, 16, 2, 18, 7'h03));
    st(18);
    emit(i_t(0, 16, 2, 18, 7'h03));
    st(18);
    emit(i_t(1, 0, 0, 19, 7'h13));
    emit(s_t(DONE_ADR, 19, 0));
    emit(j_t(0, 0));                // park
  endtask

  function automatic rv_core_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                                 rv_core_pkg::word_t a, rv_core_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (!alt) return a >> b[4:0];
        return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0])); // sign fill
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs the program on ISA rules and fills the expected lists
  function automatic int run_reference();
    rv_core_pkg::word_t x [32];
    rv_core_pkg::word_t pc, nxt, ins, a, b, adr, wb, out_r, oe_r;
    rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_j;
    logic [2:0] f3;
    logic wr, stop;
    int n;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = `RV_RESET_PC;
    out_r = '0;
    oe_r = '0;
    n = 0;
    stop = 1'b0;
    while (!stop && n < 4000) begin
      ins = ref_mem[pc[10:2]];
      f3 = ins[14:12];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt = pc + 32'd4;
      wr = 1'b0;
      wb = '0;
      n++;
      case (ins[6:0])
        7'h33: begin
          wb = ref_alu(f3, ins[30], a, b);
          wr = 1'b1;
        end
        7'h13: begin
          wb = ref_alu(f3, f3 == 3'd5 && ins[30], a, imm_i);
          wr = 1'b1;
        end
        7'h37: begin
          wb = {ins[31:12], 12'b0};
          wr = 1'b1;
        end
        7'h17: begin
          wb = pc + {ins[31:12], 12'b0};
          wr = 1'b1;
        end
        7'h03: begin
          adr = a + imm_i;
          wr = 1'b1;
          if (adr[31:4] != GPIO_BASE[31:4]) wb = ref_mem[adr[10:2]];
          else if (adr[3:0] == `RV_GPIO_OUT_OFS) wb = out_r;
          else if (adr[3:0] == `RV_GPIO_OE_OFS) wb = oe_r;
          else if (adr[3:0] == `RV_GPIO_IN_OFS) wb = GPIO_IN_VAL;
        end
        7'h23: begin
          adr = a + imm_s;
          if (adr[31:4] != GPIO_BASE[31:4]) begin
            exp_bus.push_back(rv_core_pkg::bus_req_t'{adr: adr, dat: b, sel: 4'hF,
                                                      read: 1'b0, write: 1'b1});
            ref_mem[adr[10:2]] = b;
            stop = (adr == DONE_ADR);
          end else if (adr[3:0] == `RV_GPIO_OUT_OFS) begin
            if (b != out_r) exp_out.push_back(b);
            out_r = b;
          end else if (adr[3:0] == `RV_GPIO_OE_OFS) begin
            if (b != oe_r) exp_oe.push_back(b);
            oe_r = b;
          end
        end
        7'h63: begin
          if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
              (f3 == 3'd4 && $signed(a) < $signed(b)) ||
              (f3 == 3'd5 && $signed(a) >= $signed(b))) nxt = pc + imm_b;
        end
        7'h6f: begin
          wb = pc + 32'd4;
          wr = 1'b1;
          nxt = pc + imm_j;
        end
        7'h67: begin
          wb = pc + 32'd4;
          wr = 1'b1;
          nxt = (a + imm_i) & ~32'd1;
        end
        default: ; // no-op
      endcase
      if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = wb;
      pc = nxt;
    end
    return n;
  endfunction

  task automatic check_word(input string name, input rv_core_pkg::word_t got,
                            input rv_core_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bus(input string name, input rv_core_pkg::bus_req_t got,
                           input rv_core_pkg::bus_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  initial begin
    i_clock = 1'b0;
    forever #4 i_clock = ~i_clock;
  end

  // bus slave with 0..3 busy cycles per request
  always @(posedge i_clock) begin
    if (!i_rst_n) begin
      i_busy <= 1'b0;
      busy_left <= 0;
    end else if (o_read || o_write) begin
      if (!i_busy) begin
        if (o_write) mem[o_adr[10:2]] <= o_dat;
        delay = {$random(seed)} % 4;
        i_busy <= (delay != 0);
        busy_left <= delay;
      end else begin
        busy_left <= busy_left - 1;
        if (busy_left <= 1) i_busy <= 1'b0;
      end
    end
  end

  always @(posedge i_clock) begin
    if (i_rst_n) begin
      cur = '{adr: o_adr, dat: o_dat, sel: o_sel, read: o_read, write: o_write};
      if (!first_seen) begin
        check_bus("first request", cur, first_exp);
        first_seen = 1'b1;
      end
      if (o_write && !i_busy) begin
        if (exp_bus.size() == 0) begin
          errors++;
          $display("bus write to %h that the reference never made", o_adr);
        end else begin
          check_bus("bus write", cur, exp_bus.pop_front());
        end
        if (o_adr == DONE_ADR) done = 1'b1;
      end
      if (o_gpio_out !== prev_out) begin
        if (exp_out.size() == 0) begin
          errors++;
          $display("o_gpio_out changed to %h without a matching store", o_gpio_out);
        end else check_word("o_gpio_out", o_gpio_out, exp_out.pop_front());
        prev_out = o_gpio_out;
      end
      if (o_gpio_oe !== prev_oe) begin
        if (exp_oe.size() == 0) begin
          errors++;
          $display("o_gpio_oe changed to %h without a matching store", o_gpio_oe);
        end else check_word("o_gpio_oe", o_gpio_oe, exp_oe.pop_front());
        prev_oe = o_gpio_oe;
      end
    end
  end

  always @(posedge i_clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, done store never seen", cycles);
      $display("checks %0d errors %0d", checks, errors + 1);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    i_rst_n = 1'b0;
    i_busy = 1'b0;
    i_gpio_in = GPIO_IN_VAL;
    seed = 57;
    errors = 0;
    checks = 0;
    cycles = 0;
    done = 1'b0;
    first_seen = 1'b0;
    prev_out = '0;
    prev_oe = '0;
    first_exp = '{adr: `RV_RESET_PC, dat: '0, sel: 4'hF, read: 1'b1, write: 1'b0};
    for (int i = 0; i < 512; i++) mem[i] = {16'hF11F, 7'd0, i[8:0]};
    load_program();
    mem[32'h700 >> 2] = 32'h1234_5678;
    mem[32'h704 >> 2] = 32'h0BAD_F00D;
    for (int i = 0; i < 512; i++) ref_mem[i] = mem[i];
    n_inst = run_reference();
    cycle_limit = n_inst * (2 + 2 * 4) + 8 + 200;
    repeat (8) @(posedge i_clock);
    i_rst_n <= 1'b1;
    while (!done) @(posedge i_clock);
    repeat (4) @(posedge i_clock);
    if (exp_bus.size() != 0 || exp_out.size() != 0 || exp_oe.size() != 0) begin
      errors++;
      $display("expected transactions never seen: %0d bus, %0d out, %0d oe",
               exp_bus.size(), exp_out.size(), exp_oe.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+.
rv_core_pkg.sv
rv_bus_seq.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_gpio.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f

out=$(./obj_dir/Vtb_rv_core)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
exit 1
